/* include/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data path and address width.
`define EXEC_XLEN 32

// destination register index width.
`define EXEC_REG_IDX_W 5

// alu operation code width.
`define EXEC_ALU_OP_W 4

// operand choice width, shared by both sources.
`define EXEC_SRC_SEL_W 2

`endif

/* logic/exec_pkg.sv */
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]      xlen_t;
    typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`EXEC_ALU_OP_W-1:0]  alu_op_t;
    typedef logic [`EXEC_SRC_SEL_W-1:0] src_sel_t;
    typedef logic [2:0]                 funct3_t;   // load/store size and sign.

    // alu operations, unlisted codes give zero.
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;

    localparam src_sel_t SRC1_RS1  = 2'd0;
    localparam src_sel_t SRC1_PC   = 2'd1;
    localparam src_sel_t SRC1_ZERO = 2'd2;   // code 3 also reads as zero.

    localparam src_sel_t SRC2_IMM  = 2'd0;
    localparam src_sel_t SRC2_RS2  = 2'd1;
    localparam src_sel_t SRC2_CSR  = 2'd2;
    localparam src_sel_t SRC2_ZERO = 2'd3;

    typedef enum logic {
        STAGE_EMPTY = 1'b0,
        STAGE_FULL  = 1'b1
    } stage_state_t;

endpackage

`default_nettype wire

/* logic/exec_stage_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage_ctrl
    import exec_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  valid_in,
    input  wire logic  ready_in,
    output logic       ready_out,
    output logic       valid_out,
    output logic       load,
    output xlen_t      exec_count
);

    stage_state_t state;
    logic         depart;

    assign valid_out = (state == STAGE_FULL);
    assign ready_out = (state == STAGE_EMPTY) || ready_in;   // refill while draining.
    assign load      = valid_in && ready_out;
    assign depart    = valid_out && ready_in;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= STAGE_EMPTY;
        end else if (load) begin
            state <= STAGE_FULL;   // stays full on accept and leave together.
        end else if (depart) begin
            state <= STAGE_EMPTY;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exec_count <= '0;
        end else if (depart) begin
            exec_count <= exec_count + xlen_t'(1);
        end
    end

    // a stalled item must wait for the memory stage.
    a_hold_valid: assert property (@(posedge clock) disable iff (reset)
        valid_out && !ready_in |=> valid_out);

    // decode keeps an item offered until the stage takes it.
    a_in_hold: assert property (@(posedge clock) disable iff (reset)
        valid_in && !ready_out |=> valid_in);

endmodule

`default_nettype wire

/* logic/exec_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_reg
    import exec_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic load,
    input  xlen_t     pc,
    input  xlen_t     imm,
    input  xlen_t     rs1_value,
    input  xlen_t     rs2_value,
    input  xlen_t     csr_value,
    input  alu_op_t   alu_op,
    input  src_sel_t  src1_sel,
    input  src_sel_t  src2_sel,
    input  wire logic inv_flag,
    input  wire logic jump_flag,
    input  wire logic branch_flag,
    input  wire logic reg_wen,
    input  wire logic mem_wen,
    input  wire logic mem_ren,
    input  reg_idx_t  rd,
    input  funct3_t   funct3,
    output xlen_t     pc_q,
    output xlen_t     imm_q,
    output xlen_t     rs1_value_q,
    output xlen_t     rs2_value_q,
    output xlen_t     csr_value_q,
    output alu_op_t   alu_op_q,
    output src_sel_t  src1_sel_q,
    output src_sel_t  src2_sel_q,
    output logic      inv_flag_q,
    output logic      jump_flag_q,
    output logic      branch_flag_q,
    output logic      reg_wen_q,
    output logic      mem_wen_q,
    output logic      mem_ren_q,
    output reg_idx_t  rd_q,
    output funct3_t   funct3_q
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc_q          <= '0;
            imm_q         <= '0;
            rs1_value_q   <= '0;
            rs2_value_q   <= '0;
            csr_value_q   <= '0;
            alu_op_q      <= '0;
            src1_sel_q    <= '0;
            src2_sel_q    <= '0;
            inv_flag_q    <= 1'b0;
            jump_flag_q   <= 1'b0;
            branch_flag_q <= 1'b0;
            reg_wen_q     <= 1'b0;
            mem_wen_q     <= 1'b0;
            mem_ren_q     <= 1'b0;
            rd_q          <= '0;
            funct3_q      <= '0;
        end else if (load) begin   // held while stalled.
            pc_q          <= pc;
            imm_q         <= imm;
            rs1_value_q   <= rs1_value;
            rs2_value_q   <= rs2_value;
            csr_value_q   <= csr_value;
            alu_op_q      <= alu_op;
            src1_sel_q    <= src1_sel;
            src2_sel_q    <= src2_sel;
            inv_flag_q    <= inv_flag;
            jump_flag_q   <= jump_flag;
            branch_flag_q <= branch_flag;
            reg_wen_q     <= reg_wen;
            mem_wen_q     <= mem_wen;
            mem_ren_q     <= mem_ren;
            rd_q          <= rd;
            funct3_q      <= funct3;
        end
    end

endmodule

`default_nettype wire

/* logic/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_select
    import exec_pkg::*;
(
    input  src_sel_t  src1_sel,
    input  src_sel_t  src2_sel,
    input  xlen_t     rs1_q,
    input  xlen_t     pc_q,
    input  xlen_t     imm_q,
    input  xlen_t     rs2_q,
    input  xlen_t     csr_q,
    input  wire logic valid,
    output xlen_t     src1,
    output xlen_t     src2
);

    always_comb begin
        case (src1_sel)
            SRC1_RS1: src1 = rs1_q;
            SRC1_PC:  src1 = pc_q;    // auipc and jal.
            default:  src1 = '0;      // lui path.
        endcase
    end

    always_comb begin
        case (src2_sel)
            SRC2_IMM: src2 = imm_q;
            SRC2_RS2: src2 = rs2_q;
            SRC2_CSR: src2 = csr_q;
            default:  src2 = '0;
        endcase
    end

    // code 3 has no decoder meaning for source 1.
    always_comb begin
        a_src1_code: assert #0 (!(valid && (src1_sel == 2'd3)))
            else $warning("source 1 code 3 on a valid item, read as zero");
    end

endmodule

`default_nettype wire

/* logic/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_alu
    import exec_pkg::*;
(
    input  xlen_t     src1,
    input  xlen_t     src2,
    input  alu_op_t   alu_op,
    input  wire logic inv_flag,
    output xlen_t     alu_result
);

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);   // 5 for rv32.

    logic [SHAMT_W-1:0] shamt;
    xlen_t              raw_result;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = src2[SHAMT_W-1:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            ALU_ADD:  raw_result = src1 + src2;
            ALU_SUB:  raw_result = src1 - src2;
            ALU_AND:  raw_result = src1 & src2;
            ALU_OR:   raw_result = src1 | src2;
            ALU_XOR:  raw_result = src1 ^ src2;
            ALU_SLL:  raw_result = src1 << shamt;
            ALU_SRL:  raw_result = src1 >> shamt;
            ALU_SRA:  raw_result = xlen_t'($signed(src1) >>> shamt);
            ALU_SLT:  raw_result = xlen_t'(lt_signed);
            ALU_SLTU: raw_result = xlen_t'(lt_unsigned);
            default:  raw_result = '0;
        endcase
    end

    // inverting bit 0 gives bge, bgeu and friends from the same compare.
    assign alu_result = raw_result ^ xlen_t'(inv_flag);

endmodule

`default_nettype wire

/* logic/branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolve
    import exec_pkg::*;
(
    input  xlen_t     pc_q,
    input  xlen_t     imm_q,
    input  xlen_t     alu_result,
    input  wire logic jump_flag,
    input  wire logic branch_flag,
    output logic      redirect,
    output xlen_t     redirect_target,
    output xlen_t     wb_value
);

    xlen_t branch_target;
    xlen_t link_addr;

    assign branch_target = pc_q + imm_q;
    assign link_addr     = pc_q + xlen_t'(4);

    // compare result sits in bit 0.
    assign redirect = jump_flag || (branch_flag && alu_result[0]);

    // jal and jalr both arrive here as base plus imm from the alu.
    assign redirect_target = jump_flag ? (alu_result & ~xlen_t'(1)) : branch_target;

    assign wb_value = jump_flag ? link_addr : alu_result;

endmodule

`default_nettype wire

/* logic/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top
    import exec_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic valid_in,
    output logic      ready_out,
    output logic      valid_out,
    input  wire logic ready_in,
    input  xlen_t     pc,
    input  xlen_t     imm,
    input  xlen_t     rs1_value,
    input  xlen_t     rs2_value,
    input  xlen_t     csr_value,
    input  alu_op_t   alu_op,
    input  src_sel_t  src1_sel,
    input  src_sel_t  src2_sel,
    input  wire logic inv_flag,
    input  wire logic jump_flag,
    input  wire logic branch_flag,
    input  wire logic reg_wen,
    input  wire logic mem_wen,
    input  wire logic mem_ren,
    input  reg_idx_t  rd,
    input  funct3_t   funct3,
    output logic      redirect,
    output xlen_t     redirect_target,
    output xlen_t     wb_value,
    output reg_idx_t  rd_out,
    output logic      reg_wen_out,
    output logic      mem_wen_out,
    output logic      mem_ren_out,
    output funct3_t   funct3_out,
    output xlen_t     store_data,
    output xlen_t     exec_count
);

    logic     load;
    xlen_t    pc_q;
    xlen_t    imm_q;
    xlen_t    rs1_value_q;
    xlen_t    csr_value_q;
    alu_op_t  alu_op_q;
    src_sel_t src1_sel_q;
    src_sel_t src2_sel_q;
    logic     inv_flag_q;
    logic     jump_flag_q;
    logic     branch_flag_q;
    xlen_t    src1;
    xlen_t    src2;
    xlen_t    alu_result;

    exec_stage_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .valid_in   (valid_in),
        .ready_in   (ready_in),
        .ready_out  (ready_out),
        .valid_out  (valid_out),
        .load       (load),
        .exec_count (exec_count)
    );

    exec_pipe_reg u_pipe_reg (
        .clock         (clock),
        .reset         (reset),
        .load          (load),
        .pc            (pc),
        .imm           (imm),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .csr_value     (csr_value),
        .alu_op        (alu_op),
        .src1_sel      (src1_sel),
        .src2_sel      (src2_sel),
        .inv_flag      (inv_flag),
        .jump_flag     (jump_flag),
        .branch_flag   (branch_flag),
        .reg_wen       (reg_wen),
        .mem_wen       (mem_wen),
        .mem_ren       (mem_ren),
        .rd            (rd),
        .funct3        (funct3),
        .pc_q          (pc_q),
        .imm_q         (imm_q),
        .rs1_value_q   (rs1_value_q),
        .rs2_value_q   (store_data),   // rs2 doubles as the store data.
        .csr_value_q   (csr_value_q),
        .alu_op_q      (alu_op_q),
        .src1_sel_q    (src1_sel_q),
        .src2_sel_q    (src2_sel_q),
        .inv_flag_q    (inv_flag_q),
        .jump_flag_q   (jump_flag_q),
        .branch_flag_q (branch_flag_q),
        .reg_wen_q     (reg_wen_out),
        .mem_wen_q     (mem_wen_out),
        .mem_ren_q     (mem_ren_out),
        .rd_q          (rd_out),
        .funct3_q      (funct3_out)
    );

    operand_select u_operand_select (
        .src1_sel (src1_sel_q),
        .src2_sel (src2_sel_q),
        .rs1_q    (rs1_value_q),
        .pc_q     (pc_q),
        .imm_q    (imm_q),
        .rs2_q    (store_data),
        .csr_q    (csr_value_q),
        .valid    (valid_out),
        .src1     (src1),
        .src2     (src2)
    );

    exec_alu u_alu (
        .src1       (src1),
        .src2       (src2),
        .alu_op     (alu_op_q),
        .inv_flag   (inv_flag_q),
        .alu_result (alu_result)
    );

    branch_resolve u_branch (
        .pc_q            (pc_q),
        .imm_q           (imm_q),
        .alu_result      (alu_result),
        .jump_flag       (jump_flag_q),
        .branch_flag     (branch_flag_q),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .wb_value        (wb_value)
    );

endmodule

`default_nettype wire

/* dv/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_tb
    import exec_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 3;

    // rs1/rs2 shaping for each entry.
    localparam logic [2:0] M_RAND = 3'd0;
    localparam logic [2:0] M_SH0  = 3'd1;   // shift amount 0.
    localparam logic [2:0] M_SH31 = 3'd2;   // shift amount 31.
    localparam logic [2:0] M_EQ   = 3'd3;   // rs2 equals rs1.
    localparam logic [2:0] M_SIGN = 3'd4;   // rs1 negative, rs2 positive.

    typedef struct packed {
        alu_op_t    op;
        src_sel_t   s1;
        src_sel_t   s2;
        logic       inv;
        logic       jump;
        logic       branch;
        logic [2:0] hold;
        logic [2:0] mode;
    } entry_t;

    typedef logic [140:0] bundle_t;   // every output that must hold under stall.

    logic     clock;
    logic     reset;
    logic     valid_in;
    logic     ready_out;
    logic     valid_out;
    logic     ready_in;
    xlen_t    pc;
    xlen_t    imm;
    xlen_t    rs1_value;
    xlen_t    rs2_value;
    xlen_t    csr_value;
    alu_op_t  alu_op;
    src_sel_t src1_sel;
    src_sel_t src2_sel;
    logic     inv_flag;
    logic     jump_flag;
    logic     branch_flag;
    logic     reg_wen;
    logic     mem_wen;
    logic     mem_ren;
    reg_idx_t rd;
    funct3_t  funct3;
    logic     redirect;
    xlen_t    redirect_target;
    xlen_t    wb_value;
    reg_idx_t rd_out;
    logic     reg_wen_out;
    logic     mem_wen_out;
    logic     mem_ren_out;
    funct3_t  funct3_out;
    xlen_t    store_data;
    xlen_t    exec_count;

    entry_t      table_q[$];
    logic [15:0] lfsr_state;
    logic        table_ready;
    int          limit_cycles;
    int          errors;
    int          checks;
    int          tests_run;
    int          accept_count;
    xlen_t       exp_wb;
    xlen_t       exp_target;
    logic        exp_redirect;
    xlen_t       exp_store;
    reg_idx_t    exp_rd;
    funct3_t     exp_funct3;
    logic [2:0]  exp_ctrl;   // reg_wen, mem_wen, mem_ren.

    exec_top UUT (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic xlen_t random_bits(input int n);
        xlen_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], lfsr_next_bit()};
        end
        return w;
    endfunction

    // expected stage outputs worked out from the ISA rules.
    function automatic void ref_model(input entry_t e, input xlen_t m_pc, input xlen_t m_imm,
                                      input xlen_t m_rs1, input xlen_t m_rs2,
                                      input xlen_t m_csr, output xlen_t m_wb,
                                      output logic m_redir, output xlen_t m_target);
        xlen_t      a;
        xlen_t      b;
        xlen_t      r;
        xlen_t      ones;
        logic [4:0] sh;
        ones = '1;
        a = (e.s1 == SRC1_RS1) ? m_rs1 : (e.s1 == SRC1_PC) ? m_pc : '0;
        case (e.s2)
            SRC2_IMM: b = m_imm;
            SRC2_RS2: b = m_rs2;
            SRC2_CSR: b = m_csr;
            default:  b = '0;
        endcase
        sh = b[4:0];
        case (e.op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 32'd1;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = (a >> sh) | ({32{a[31]}} & ~(ones >> sh));   // refill the sign.
            ALU_SLT:  r = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ALU_SLTU: r = {31'd0, a < b};
            default:  r = '0;
        endcase
        r[0] = r[0] ^ e.inv;
        m_redir  = e.jump || (e.branch && r[0]);
        m_target = e.jump ? {r[31:1], 1'b0} : m_pc + m_imm;
        m_wb     = e.jump ? m_pc + 32'd4 : r;
    endfunction

    function automatic bundle_t output_bundle();
        return {valid_out, redirect, redirect_target, wb_value, rd_out, reg_wen_out,
                mem_wen_out, mem_ren_out, funct3_out, store_data, exec_count};
    endfunction

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        checks++;
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_random_fields();
        pc        = random_bits(32) & ~xlen_t'(3);   // word aligned.
        imm       = random_bits(32);
        rs1_value = random_bits(32);
        rs2_value = random_bits(32);
        csr_value = random_bits(32);
        rd        = reg_idx_t'(random_bits(5));
        funct3    = funct3_t'(random_bits(3));
        reg_wen   = lfsr_next_bit();
        mem_wen   = lfsr_next_bit();
        mem_ren   = lfsr_next_bit();
    endtask

    task automatic drive_entry(input entry_t e);
        drive_random_fields();
        case (e.mode)
            M_SH0:  rs2_value[4:0] = 5'd0;
            M_SH31: rs2_value[4:0] = 5'd31;
            M_EQ:   rs2_value = rs1_value;
            M_SIGN: begin
                rs1_value[31] = 1'b1;
                rs2_value[31] = 1'b0;
            end
            default: ;
        endcase
        alu_op      = e.op;
        src1_sel    = e.s1;
        src2_sel    = e.s2;
        inv_flag    = e.inv;
        jump_flag   = e.jump;
        branch_flag = e.branch;
        ref_model(e, pc, imm, rs1_value, rs2_value, csr_value, exp_wb, exp_redirect, exp_target);
        exp_store  = rs2_value;
        exp_rd     = rd;
        exp_funct3 = funct3;
        exp_ctrl   = {reg_wen, mem_wen, mem_ren};
    endtask

    task automatic check_results();
        check_value("valid_out", 32'd1, xlen_t'(valid_out));
        check_value("wb_value", exp_wb, wb_value);
        check_value("redirect", xlen_t'(exp_redirect), xlen_t'(redirect));
        check_value("redirect_target", exp_target, redirect_target);
        check_value("store_data", exp_store, store_data);
        check_value("rd_out", xlen_t'(exp_rd), xlen_t'(rd_out));
        check_value("funct3_out", xlen_t'(exp_funct3), xlen_t'(funct3_out));
        check_value("reg_wen_out", xlen_t'(exp_ctrl[2]), xlen_t'(reg_wen_out));
        check_value("mem_wen_out", xlen_t'(exp_ctrl[1]), xlen_t'(mem_wen_out));
        check_value("mem_ren_out", xlen_t'(exp_ctrl[0]), xlen_t'(mem_ren_out));
        check_value("exec_count", xlen_t'(accept_count - 1), exec_count);   // not left yet.
    endtask

    task automatic run_entry(input int idx);
        entry_t  e;
        logic    accepted;
        bundle_t snap;
        int      errs_before;
        e = table_q[idx];
        errs_before = errors;
        @(negedge clock);
        drive_entry(e);
        valid_in = 1'b1;
        ready_in = (e.hold == 3'd0);
        accepted = 1'b0;
        while (!accepted) begin
            #1;
            accepted = ready_out;
            @(posedge clock);
        end
        accept_count++;
        @(negedge clock);
        valid_in = 1'b0;
        drive_random_fields();   // registered outputs must not follow the inputs.
        jump_flag = ~jump_flag;
        inv_flag  = ~inv_flag;
        check_results();
        snap = output_bundle();
        repeat (e.hold) begin
            @(negedge clock);
            check_value("ready_out", 32'd0, xlen_t'(ready_out));
            checks++;
            if (output_bundle() !== snap) begin
                $display("Fail at %0t: held outputs expected %h, got %h",
                         $time, snap, output_bundle());
                errors++;
            end
        end
        ready_in = 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_value("valid_out", 32'd0, xlen_t'(valid_out));
        check_value("exec_count", xlen_t'(accept_count), exec_count);
        tests_run++;
        $display("test %0d op %0d src %0d/%0d hold %0d: %s", idx + 1, e.op, e.s1, e.s2,
                 e.hold, (errors == errs_before) ? "passed" : "failed");
    endtask

    task automatic build_table();
        //                op        s1         s2         inv   jump  branch hold  mode
        table_q.push_back('{ALU_ADD,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_SUB,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd2, M_RAND});
        table_q.push_back('{ALU_AND,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_OR,   SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_XOR,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd3, M_RAND});
        table_q.push_back('{ALU_SLL,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_SH0});
        table_q.push_back('{ALU_SLL,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_SH31});
        table_q.push_back('{ALU_SRL,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_SH31});
        table_q.push_back('{ALU_SRA,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd1, M_SH31});
        table_q.push_back('{ALU_SRA,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_SH0});
        table_q.push_back('{ALU_SLT,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_SLTU, SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_SLT,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_SIGN});
        table_q.push_back('{ALU_SLTU, SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b0, 3'd0, M_SIGN});
        table_q.push_back('{ALU_ADD,  SRC1_PC,   SRC2_IMM,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_ADD,  SRC1_ZERO, SRC2_IMM,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_OR,   SRC1_RS1,  SRC2_CSR,  1'b0, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_ADD,  SRC1_RS1,  SRC2_ZERO, 1'b0, 1'b0, 1'b0, 3'd4, M_RAND});
        table_q.push_back('{ALU_SLT,  SRC1_RS1,  SRC2_RS2,  1'b1, 1'b0, 1'b0, 3'd0, M_SIGN});
        table_q.push_back('{ALU_SLTU, SRC1_RS1,  SRC2_RS2,  1'b1, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_SUB,  SRC1_RS1,  SRC2_RS2,  1'b1, 1'b0, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_SLTU, SRC1_RS1,  SRC2_RS2,  1'b1, 1'b0, 1'b1, 3'd0, M_EQ});
        table_q.push_back('{ALU_SLT,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b1, 3'd0, M_EQ});
        table_q.push_back('{ALU_SLT,  SRC1_RS1,  SRC2_RS2,  1'b0, 1'b0, 1'b1, 3'd1, M_SIGN});
        table_q.push_back('{ALU_ADD,  SRC1_PC,   SRC2_IMM,  1'b0, 1'b1, 1'b0, 3'd0, M_RAND});
        table_q.push_back('{ALU_ADD,  SRC1_RS1,  SRC2_IMM,  1'b0, 1'b1, 1'b0, 3'd2, M_RAND});
    endtask

    initial begin
        wait (table_ready);
        #(limit_cycles * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int max_hold;
        reset       = 1'b1;
        valid_in    = 1'b0;
        ready_in    = 1'b0;
        pc          = '0;
        imm         = '0;
        rs1_value   = '0;
        rs2_value   = '0;
        csr_value   = '0;
        alu_op      = ALU_ADD;
        src1_sel    = SRC1_RS1;
        src2_sel    = SRC2_IMM;
        inv_flag    = 1'b0;
        jump_flag   = 1'b0;
        branch_flag = 1'b0;
        reg_wen     = 1'b0;
        mem_wen     = 1'b0;
        mem_ren     = 1'b0;
        rd          = '0;
        funct3      = '0;
        lfsr_state  = 16'd26;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        accept_count = 0;
        table_ready  = 1'b0;
        build_table();
        max_hold = 0;
        foreach (table_q[i]) begin
            if (int'(table_q[i].hold) > max_hold) max_hold = int'(table_q[i].hold);
        end
        limit_cycles = table_q.size() * (max_hold + 4) + RESET_CYCLES;
        table_ready  = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #1;
        check_value("valid_out", 32'd0, xlen_t'(valid_out));
        check_value("ready_out", 32'd1, xlen_t'(ready_out));
        check_value("exec_count", 32'd0, exec_count);
        tests_run++;
        $display("test 0 reset: %s", (errors == 0) ? "passed" : "failed");
        foreach (table_q[i]) begin
            run_entry(i);
        end
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
logic/exec_pkg.sv
logic/exec_stage_ctrl.sv
logic/exec_pipe_reg.sv
logic/operand_select.sv
logic/exec_alu.sv
logic/branch_resolve.sv
logic/exec_top.sv
dv/exec_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench.
# Any variable can be overridden, e.g. make run TOP=exec_tb OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= exec_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only when the pass line shows up in the output.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
